// ==== mem_pkg.sv ====
package mem_pkg;

    typedef logic [63:0] xlen_t;       // data word and byte address
    typedef logic [4:0]  reg_addr_t;   // x0..x31
    typedef logic [7:0]  ram_index_t;  // word index into the data RAM

    localparam int RAM_DEPTH = 256;    // 64-bit words, 2 KiB

    // load funct3 encoding, stores reuse lb/lh/lw/ld
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        ld  = 3'b011,
        lbu = 3'b100,
        lhu = 3'b101,
        lwu = 3'b110
    } mem_size_e;

    // register result source in writeback
    typedef enum logic [1:0] {
        alu      = 2'd0,
        mem      = 2'd1,
        pc_plus4 = 2'd2   // jal/jalr link value
    } wreg_sel_e;

    // execute -> memory stage, 205 bits
    typedef struct packed {
        xlen_t      store_data;  // rs2 value
        logic       mem_wen;
        logic       mem_ren;
        mem_size_e  size;
        wreg_sel_e  wreg_sel;
        logic       reg_wen;
        reg_addr_t  rd;
        xlen_t      alu_result;  // also the memory address
        xlen_t      pc;
    } ex_mem_bus_t;

    // memory stage -> writeback, 200 bits
    typedef struct packed {
        logic       reg_wen;
        reg_addr_t  rd;
        wreg_sel_e  wreg_sel;
        xlen_t      load_data;
        xlen_t      alu_result;
        xlen_t      pc;
    } mem_wb_bus_t;

    // one access to the data RAM
    typedef struct packed {
        ram_index_t index;
        logic       we;
        logic [7:0] mask;   // one bit per byte lane
        xlen_t      wdata;
    } ram_req_t;

endpackage

// ==== data_ram.sv ====
`timescale 1ns/1ps

module data_ram (
    input  logic              clk,
    input  mem_pkg::ram_req_t req,
    output mem_pkg::xlen_t    rdata
);
    import mem_pkg::*;

    xlen_t words [RAM_DEPTH];

    // asynchronous read port
    assign rdata = words[req.index];

    // byte-lane write, lanes outside the mask keep their old value
    always_ff @(posedge clk) begin
        if (req.we) begin
            for (int i = 0; i < 8; i++) begin
                if (req.mask[i]) begin
                    words[req.index][i*8 +: 8] <= req.wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

// ==== mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  logic              host_req,
    input  logic              host_we,
    input  mem_pkg::xlen_t    host_addr,
    input  mem_pkg::xlen_t    host_wdata,
    input  mem_pkg::ram_req_t ms_req,
    input  mem_pkg::xlen_t    ram_rdata,
    output logic              mem_grant,
    output mem_pkg::ram_req_t ram_req,
    output logic              host_rvalid,
    output mem_pkg::xlen_t    host_rdata
);
    import mem_pkg::*;

    ram_req_t host_side;

    // host strobe cannot wait, so it always wins
    assign mem_grant = !host_req;

    always_comb begin
        host_side.index = host_addr[10:3];  // byte address to word index
        host_side.we    = host_we;
        host_side.mask  = 8'hff;            // host works on whole words
        host_side.wdata = host_wdata;
    end

    always_comb begin
        if (host_req) begin
            ram_req = host_side;  // stalled store request is dropped here
        end else begin
            ram_req = ms_req;
        end
    end

    // read response one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            host_rvalid <= 1'b0;
        end else begin
            host_rvalid <= host_req && !host_we;
        end
    end

    always_ff @(posedge clk) begin
        if (host_req && !host_we) begin
            host_rdata <= ram_rdata;  // old word, write lands at this edge
        end
    end

endmodule

// ==== load_store_align.sv ====
`timescale 1ns/1ps

module load_store_align (
    input  mem_pkg::xlen_t      addr,
    input  mem_pkg::mem_size_e  size,
    input  mem_pkg::xlen_t      store_data,
    input  logic                mem_wen,
    input  mem_pkg::xlen_t      ram_rdata,
    output mem_pkg::ram_req_t   ms_req,
    output mem_pkg::xlen_t      load_data
);
    import mem_pkg::*;

    logic [2:0] offset;     // byte within the word
    logic [5:0] shift;      // same offset in bits
    logic [7:0] base_mask;
    xlen_t      lane_data;

    assign offset = addr[2:0];
    assign shift  = {offset, 3'b000};

    // lanes touched by the access, before placement
    always_comb begin
        case (size)
            lb, lbu: base_mask = 8'h01;
            lh, lhu: base_mask = 8'h03;
            lw, lwu: base_mask = 8'h0f;
            default: base_mask = 8'hff;
        endcase
    end

    // store side
    always_comb begin
        ms_req.index = addr[10:3];
        ms_req.we    = mem_wen;
        ms_req.mask  = base_mask << offset;
        ms_req.wdata = store_data << shift;  // aligned access keeps data in the word
    end

    // load side, move the lanes down then extend
    always_comb begin
        lane_data = ram_rdata >> shift;
        case (size)
            lb:      load_data = {{56{lane_data[7]}}, lane_data[7:0]};
            lbu:     load_data = {56'd0, lane_data[7:0]};
            lh:      load_data = {{48{lane_data[15]}}, lane_data[15:0]};
            lhu:     load_data = {48'd0, lane_data[15:0]};
            lw:      load_data = {{32{lane_data[31]}}, lane_data[31:0]};
            lwu:     load_data = {32'd0, lane_data[31:0]};
            default: load_data = lane_data;  // ld
        endcase
    end

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 es_to_ms_valid,
    input  mem_pkg::ex_mem_bus_t es_to_ms_bus,
    output logic                 ms_allowin,
    input  logic                 ws_allowin,
    input  logic                 mem_grant,
    output logic                 ms_to_ws_valid,
    output mem_pkg::mem_wb_bus_t ms_to_ws_bus,
    output mem_pkg::xlen_t       ms_addr,
    output mem_pkg::mem_size_e   ms_size,
    output mem_pkg::xlen_t       ms_store_data,
    output logic                 ms_mem_wen,
    input  mem_pkg::xlen_t       load_data
);
    import mem_pkg::*;

    logic        ms_valid;
    logic        ms_ready_go;
    ex_mem_bus_t ms_bus;   // op held in this stage

    // op waits here while the host owns the RAM
    assign ms_ready_go    = mem_grant;
    assign ms_allowin     = !ms_valid || (ms_ready_go && ws_allowin);
    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) begin
            ms_bus <= es_to_ms_bus;
        end
    end

    // access request towards the aligner
    assign ms_addr       = ms_bus.alu_result;
    assign ms_size       = ms_bus.size;
    assign ms_store_data = ms_bus.store_data;
    assign ms_mem_wen    = ms_valid && ms_bus.mem_wen;  // empty stage never writes

    always_comb begin
        ms_to_ws_bus.reg_wen    = ms_bus.reg_wen;
        ms_to_ws_bus.rd         = ms_bus.rd;
        ms_to_ws_bus.wreg_sel   = ms_bus.wreg_sel;
        ms_to_ws_bus.load_data  = ms_bus.mem_ren ? load_data : '0;
        ms_to_ws_bus.alu_result = ms_bus.alu_result;
        ms_to_ws_bus.pc         = ms_bus.pc;
    end

endmodule

// ==== wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ms_to_ws_valid,
    input  mem_pkg::mem_wb_bus_t ms_to_ws_bus,
    output logic                 ws_allowin,
    output logic                 rf_wen,
    output mem_pkg::reg_addr_t   rf_waddr,
    output mem_pkg::xlen_t       rf_wdata
);
    import mem_pkg::*;

    logic        ws_valid;
    logic        ws_ready_go;
    mem_wb_bus_t ws_bus;

    // register file write never stalls
    assign ws_ready_go = 1'b1;
    assign ws_allowin  = !ws_valid || ws_ready_go;

    always_ff @(posedge clk) begin
        if (rst) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_to_ws_valid && ws_allowin) begin
            ws_bus <= ms_to_ws_bus;
        end
    end

    // x0 stays zero, so never strobe it
    assign rf_wen   = ws_valid && ws_ready_go && ws_bus.reg_wen && (ws_bus.rd != 5'd0);
    assign rf_waddr = ws_bus.rd;

    always_comb begin
        case (ws_bus.wreg_sel)
            mem:      rf_wdata = ws_bus.load_data;
            pc_plus4: rf_wdata = ws_bus.pc + 64'd4;   // link address
            default:  rf_wdata = ws_bus.alu_result;
        endcase
    end

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 es_to_ms_valid,
    input  mem_pkg::ex_mem_bus_t es_to_ms_bus,
    output logic                 ms_allowin,
    input  logic                 host_req,
    input  logic                 host_we,
    input  mem_pkg::xlen_t       host_addr,
    input  mem_pkg::xlen_t       host_wdata,
    output logic                 host_rvalid,
    output mem_pkg::xlen_t       host_rdata,
    output logic                 rf_wen,
    output mem_pkg::reg_addr_t   rf_waddr,
    output mem_pkg::xlen_t       rf_wdata
);
    import mem_pkg::*;

    logic        ws_allowin;
    logic        mem_grant;
    logic        ms_to_ws_valid;
    mem_wb_bus_t ms_to_ws_bus;
    xlen_t       ms_addr;
    mem_size_e   ms_size;
    xlen_t       ms_store_data;
    logic        ms_mem_wen;
    xlen_t       load_data;
    ram_req_t    ms_req;
    ram_req_t    ram_req;
    xlen_t       ram_rdata;

    mem_stage mem_stage_i (
        .clk            (clk),
        .rst            (rst),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ms_allowin     (ms_allowin),
        .ws_allowin     (ws_allowin),
        .mem_grant      (mem_grant),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ms_addr        (ms_addr),
        .ms_size        (ms_size),
        .ms_store_data  (ms_store_data),
        .ms_mem_wen     (ms_mem_wen),
        .load_data      (load_data)
    );

    wb_stage wb_stage_i (
        .clk            (clk),
        .rst            (rst),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .rf_wen         (rf_wen),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata)
    );

    load_store_align align_i (
        .addr       (ms_addr),
        .size       (ms_size),
        .store_data (ms_store_data),
        .mem_wen    (ms_mem_wen),
        .ram_rdata  (ram_rdata),
        .ms_req     (ms_req),
        .load_data  (load_data)
    );

    mem_arbiter arbiter_i (
        .clk         (clk),
        .rst         (rst),
        .host_req    (host_req),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .ms_req      (ms_req),
        .ram_rdata   (ram_rdata),
        .mem_grant   (mem_grant),
        .ram_req     (ram_req),
        .host_rvalid (host_rvalid),
        .host_rdata  (host_rdata)
    );

    data_ram ram_i (
        .clk   (clk),
        .req   (ram_req),
        .rdata (ram_rdata)
    );

endmodule

// ==== lsu_assertions.sv ====
`timescale 1ns/1ps

module lsu_assertions (
    input logic                 clk,
    input logic                 rst,
    input logic                 es_to_ms_valid,
    input mem_pkg::ex_mem_bus_t es_to_ms_bus,
    input logic                 ms_allowin,
    input logic                 host_req,
    input logic                 host_we,
    input logic                 host_rvalid,
    input logic                 rf_wen,
    input mem_pkg::reg_addr_t   rf_waddr
);

    int failures = 0;

    // read response exactly one cycle after a host read, never otherwise
    rvalid_after_read: assert property (@(posedge clk) disable iff (rst)
        (host_req && !host_we) |=> host_rvalid)
        else begin
            failures++;
            $error("host read got no host_rvalid in the next cycle");
        end

    no_rvalid_without_read: assert property (@(posedge clk) disable iff (rst)
        !(host_req && !host_we) |=> !host_rvalid)
        else begin
            failures++;
            $error("host_rvalid without a host read in the cycle before");
        end

    held_bus_stable: assert property (@(posedge clk) disable iff (rst)
        (es_to_ms_valid && !ms_allowin) |=> (es_to_ms_valid && $stable(es_to_ms_bus)))
        else begin
            failures++;
            $error("execute bus changed while waiting for ms_allowin");
        end

    no_x0_write: assert property (@(posedge clk) disable iff (rst)
        rf_wen |-> (rf_waddr != 5'd0))
        else begin
            failures++;
            $error("register write strobe for x0");
        end

    controls_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({ms_allowin, rf_wen, host_rvalid}))
        else begin
            failures++;
            $error("unknown value on ms_allowin, rf_wen or host_rvalid");
        end

endmodule

// ==== lsu_checker.sv ====
`timescale 1ns/1ps

module lsu_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 es_to_ms_valid,
    input  mem_pkg::ex_mem_bus_t es_to_ms_bus,
    input  logic                 ms_allowin,
    input  logic                 host_req,
    input  logic                 host_we,
    input  mem_pkg::xlen_t       host_addr,
    input  mem_pkg::xlen_t       host_wdata,
    input  logic                 host_rvalid,
    input  mem_pkg::xlen_t       host_rdata,
    input  logic                 rf_wen,
    input  mem_pkg::reg_addr_t   rf_waddr,
    input  mem_pkg::xlen_t       rf_wdata,
    output int                   check_count,
    output int                   error_count,
    output int                   outstanding
);
    import mem_pkg::*;

    typedef struct packed {
        int    due;    // cycle of the expected strobe
        logic  wen;
        xlen_t addr;
        xlen_t data;
    } expect_t;

    xlen_t       shadow [32];
    expect_t     wb_q [$];
    expect_t     rd_q [$];
    ex_mem_bus_t stage_op;     // what the memory stage should hold
    logic        stage_full;
    int          cycle;

    initial begin
        check_count = 0;
        error_count = 0;
        outstanding = 0;
    end

    task automatic check(input string name, input xlen_t expected, input xlen_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
        end
    endtask

    // size code: low two bits give the byte count, bit 2 means unsigned
    function automatic xlen_t merge_store(xlen_t word, xlen_t data, logic [2:0] off,
                                          mem_size_e size);
        int    nbytes;
        xlen_t merged;
        nbytes = 1 << size[1:0];
        merged = word;
        for (int i = 0; i < nbytes; i++) begin
            merged[6'(8 * (int'(off) + i)) +: 8] = data[6'(8 * i) +: 8];
        end
        return merged;
    endfunction

    function automatic xlen_t load_value(xlen_t word, logic [2:0] off, mem_size_e size);
        int    nbytes;
        xlen_t v;
        nbytes = 1 << size[1:0];
        v      = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < nbytes) begin
                v[6'(8 * i) +: 8] = word[6'(8 * (int'(off) + i)) +: 8];
            end else if (!size[2]) begin
                v[6'(8 * i) +: 8] = {8{v[6'(8 * nbytes - 1)]}};  // sign fill
            end
        end
        return v;
    endfunction

    always @(negedge clk) begin
        expect_t    item;
        logic [4:0] widx;
        xlen_t      loaded;
        if (rst) begin
            stage_full = 1'b0;
            wb_q.delete();
            rd_q.delete();
            cycle = 0;
            check("rf_wen", 64'd0, 64'(rf_wen));
            check("host_rvalid", 64'd0, 64'(host_rvalid));
            check("ms_allowin", 64'd1, 64'(ms_allowin));
        end else begin
            cycle++;
            if (wb_q.size() != 0 && wb_q[0].due == cycle) begin
                item = wb_q.pop_front();
                check("rf_wen", 64'(item.wen), 64'(rf_wen));
                if (item.wen) begin
                    check("rf_waddr", item.addr, 64'(rf_waddr));
                    check("rf_wdata", item.data, rf_wdata);
                end
            end else begin
                check("rf_wen", 64'd0, 64'(rf_wen));
            end
            if (rd_q.size() != 0 && rd_q[0].due == cycle) begin
                item = rd_q.pop_front();
                check("host_rvalid", 64'd1, 64'(host_rvalid));
                check("host_rdata", item.data, host_rdata);
            end else begin
                check("host_rvalid", 64'd0, 64'(host_rvalid));
            end
            // held op waits while the host has the RAM
            check("ms_allowin", 64'(!stage_full || !host_req), 64'(ms_allowin));
            if (host_req) begin
                widx = host_addr[7:3];
                item.due  = cycle + 1;
                item.wen  = 1'b1;
                item.addr = host_addr;
                item.data = shadow[widx];   // old word, before any write this cycle
                if (host_we) shadow[widx] = host_wdata;
                else rd_q.push_back(item);
            end else if (stage_full) begin
                widx   = stage_op.alu_result[7:3];
                loaded = '0;
                if (stage_op.mem_wen) begin
                    shadow[widx] = merge_store(shadow[widx], stage_op.store_data,
                                               stage_op.alu_result[2:0], stage_op.size);
                end
                if (stage_op.mem_ren) begin
                    loaded = load_value(shadow[widx], stage_op.alu_result[2:0], stage_op.size);
                end
                item.due  = cycle + 1;
                item.wen  = stage_op.reg_wen && (stage_op.rd != 5'd0);
                item.addr = 64'(stage_op.rd);
                case (stage_op.wreg_sel)
                    mem:      item.data = loaded;
                    pc_plus4: item.data = stage_op.pc + 64'd4;
                    default:  item.data = stage_op.alu_result;
                endcase
                wb_q.push_back(item);
                stage_full = 1'b0;
            end
            if (es_to_ms_valid && ms_allowin) begin
                stage_op   = es_to_ms_bus;
                stage_full = 1'b1;
            end
        end
        outstanding = wb_q.size() + rd_q.size() + (stage_full ? 1 : 0);
    end

endmodule

// ==== tb_lsu.sv ====
`timescale 1ns/1ps

module tb_lsu;
    import mem_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int PRELOAD      = 32;    // words reachable by test addresses
    localparam int RUN_CYCLES   = 2000;
    localparam int TOTAL_CYCLES = RESET_CYCLES + PRELOAD + RUN_CYCLES + 32;

    logic        clk = 1'b0;
    logic        rst;
    logic        es_to_ms_valid;
    ex_mem_bus_t es_to_ms_bus;
    logic        ms_allowin;
    logic        host_req;
    logic        host_we;
    xlen_t       host_addr;
    xlen_t       host_wdata;
    logic        host_rvalid;
    xlen_t       host_rdata;
    logic        rf_wen;
    reg_addr_t   rf_waddr;
    xlen_t       rf_wdata;
    int          check_count;
    int          error_count;
    int          outstanding;
    logic [31:0] lfsr_state;

    lsu_top dut_i (.*);

    lsu_checker checker_i (.*);

    bind lsu_top lsu_assertions assertions_i (
        .clk            (clk),
        .rst            (rst),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ms_allowin     (ms_allowin),
        .host_req       (host_req),
        .host_we        (host_we),
        .host_rvalid    (host_rvalid),
        .rf_wen         (rf_wen),
        .rf_waddr       (rf_waddr)
    );

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r          = {r[62:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    task automatic make_op(output ex_mem_bus_t op);
        logic [1:0] kind;
        logic [2:0] sz;
        logic [2:0] off;
        int         nbytes;
        op            = '0;
        kind          = 2'(rand_bits(2));
        op.pc         = rand_bits(64) & ~64'h3;
        op.rd         = 5'(rand_bits(5));
        op.reg_wen    = (2'(rand_bits(2)) != 2'd0);
        op.store_data = rand_bits(64);
        op.wreg_sel   = (rand_bits(1) != 0) ? pc_plus4 : alu;
        op.alu_result = rand_bits(64);   // plain alu op keeps this
        if (kind == 2'd0) begin          // store
            op.mem_wen = 1'b1;
            op.reg_wen = 1'b0;
            op.size    = mem_size_e'({1'b0, 2'(rand_bits(2))});
        end else if (kind == 2'd1) begin // load
            sz = 3'(rand_bits(3));
            op.size     = mem_size_e'((sz == 3'b111) ? 3'b011 : sz);
            op.mem_ren  = 1'b1;
            op.wreg_sel = mem;
        end
        if (op.mem_wen || op.mem_ren) begin
            nbytes        = 1 << op.size[1:0];
            off           = 3'(rand_bits(3)) & 3'(8 - nbytes);  // natural alignment
            op.alu_result = {56'd0, 5'(rand_bits(5)), off};
        end
    endtask

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD * 2);
        $display("watchdog expired, the pipeline did not drain in time");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        ex_mem_bus_t next_op;
        logic        accepted;
        int          assert_fails;
        lfsr_state     = 32'h8c4e_3cb1;
        rst            = 1'b1;
        es_to_ms_valid = 1'b0;
        es_to_ms_bus   = '0;
        host_req       = 1'b0;
        host_we        = 1'b0;
        host_addr      = '0;
        host_wdata     = '0;
        accepted       = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #0.5;
        rst = 1'b0;
        // fill the test words through the host port
        for (int w = 0; w < PRELOAD; w++) begin
            host_req   = 1'b1;
            host_we    = 1'b1;
            host_addr  = {56'd0, 5'(w), 3'b000};
            host_wdata = rand_bits(64);
            @(posedge clk);
            #0.5;
        end
        for (int c = 0; c < RUN_CYCLES; c++) begin
            if (!es_to_ms_valid || accepted) begin   // current op is gone
                make_op(next_op);
                es_to_ms_bus   = next_op;
                es_to_ms_valid = (2'(rand_bits(2)) != 2'd0);
            end
            host_req   = (2'(rand_bits(2)) == 2'd0);
            host_we    = (rand_bits(1) != 0);
            host_addr  = {56'd0, 5'(rand_bits(5)), 3'b000};
            host_wdata = rand_bits(64);
            @(negedge clk);
            accepted = es_to_ms_valid && ms_allowin;
            @(posedge clk);
            #0.5;
        end
        // no host traffic, so a held op goes in at the next edge
        host_req = 1'b0;
        if (accepted) es_to_ms_valid = 1'b0;
        @(posedge clk);
        #0.5;
        es_to_ms_valid = 1'b0;
        do @(posedge clk); while (outstanding != 0);
        repeat (4) @(posedge clk);
        assert_fails = dut_i.assertions_i.failures;
        $display("checks %0d, mismatches %0d, assertion failures %0d",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
mem_pkg.sv
data_ram.sv
mem_arbiter.sv
load_store_align.sv
mem_stage.sv
wb_stage.sv
lsu_top.sv
lsu_assertions.sv
lsu_checker.sv
tb_lsu.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_lsu
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
